//--- common/cpuPkg.sv
package cpuPkg;

    localparam int WORD_SIZE = 16;
    localparam int NUM_REGS = 4;

    typedef logic [WORD_SIZE-1:0] wordT;          // data, address or instruction
    typedef logic [$clog2(NUM_REGS)-1:0] regAddrT;
    typedef logic [7:0] immT;                     // raw immediate field

    // instruction bits 15..12
    typedef enum logic [3:0] {
        OP_BNE = 4'd0,
        OP_BEQ = 4'd1,
        OP_ADI = 4'd4,
        OP_LHI = 4'd6,
        OP_LWD = 4'd7,
        OP_SWD = 4'd8,
        OP_JMP = 4'd9,
        OP_RTYPE = 4'd15
    } opcodeE;

    // instruction bits 5..0, only meaningful with OP_RTYPE
    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } funcE;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASSB                                 // lhi
    } aluOpE;

    typedef enum logic [1:0] {
        FWD_REGFILE,
        FWD_FROMMEM,                              // ex/mem result
        FWD_FROMWB                                // mem/wb write-back value
    } fwdSelE;

endpackage

//--- src/regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic            clk,
    input  logic            rst,
    input  cpuPkg::regAddrT readA,
    input  cpuPkg::regAddrT readB,
    input  cpuPkg::regAddrT writeAddr,
    input  cpuPkg::wordT    writeData,
    input  logic            writeEn,
    output cpuPkg::wordT    dataA,
    output cpuPkg::wordT    dataB
);
    import cpuPkg::*;

    wordT regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // same-cycle write shows up on the read ports
    assign dataA = (writeEn && writeAddr == readA) ? writeData : regs[readA];
    assign dataB = (writeEn && writeAddr == readB) ? writeData : regs[readB];

endmodule

//--- src/alu.sv
`timescale 1ns/100ps

module alu (
    input  cpuPkg::wordT  a,
    input  cpuPkg::wordT  b,
    input  cpuPkg::aluOpE op,
    output cpuPkg::wordT  result,
    output logic          zero
);
    import cpuPkg::*;

    always_comb begin
        case (op)
            ALU_ADD:   result = a + b;
            ALU_SUB:   result = a - b;
            ALU_AND:   result = a & b;
            ALU_OR:    result = a | b;
            ALU_PASSB: result = b;
            default:   result = '0;
        endcase
    end

    // compares the operands directly, branches use rs and rt here
    assign zero = (a == b);

endmodule

//--- src/controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
    input  cpuPkg::wordT    instr,
    output logic            regWrite,
    output logic            memRead,
    output logic            memWrite,
    output logic            memToReg,
    output logic            aluSrcImm,
    output cpuPkg::aluOpE   aluOp,
    output logic            isBranch,
    output logic            branchOnEq,
    output logic            isJump,
    output logic            isWwd,
    output logic            isHalt,
    output logic            usesRt,
    output cpuPkg::regAddrT writeReg,
    output cpuPkg::wordT    imm
);
    import cpuPkg::*;

    opcodeE opcode;
    funcE func;
    immT rawImm;
    wordT signImm;

    assign opcode = opcodeE'(instr[15:12]);
    assign func = funcE'(instr[5:0]);
    assign rawImm = instr[7:0];
    assign signImm = {{8{rawImm[7]}}, rawImm};

    always_comb begin
        regWrite = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        aluSrcImm = 1'b0;
        aluOp = ALU_ADD;
        isBranch = 1'b0;
        branchOnEq = 1'b0;
        isJump = 1'b0;
        isWwd = 1'b0;
        isHalt = 1'b0;
        usesRt = 1'b0;
        writeReg = instr[9:8];                    // rt for i-type
        imm = signImm;
        case (opcode)
            OP_RTYPE: begin
                writeReg = instr[7:6];            // rd
                regWrite = 1'b1;
                usesRt = 1'b1;
                case (func)
                    FN_ADD: aluOp = ALU_ADD;
                    FN_SUB: aluOp = ALU_SUB;
                    FN_AND: aluOp = ALU_AND;
                    FN_ORR: aluOp = ALU_OR;
                    FN_WWD: begin
                        regWrite = 1'b0;
                        usesRt = 1'b0;
                        isWwd = 1'b1;
                    end
                    FN_HLT: begin
                        regWrite = 1'b0;
                        usesRt = 1'b0;
                        isHalt = 1'b1;
                    end
                    default: begin
                        regWrite = 1'b0;
                        usesRt = 1'b0;
                    end
                endcase
            end
            OP_ADI: begin
                regWrite = 1'b1;
                aluSrcImm = 1'b1;
            end
            OP_LHI: begin
                regWrite = 1'b1;
                aluSrcImm = 1'b1;
                aluOp = ALU_PASSB;
                imm = {rawImm, 8'h00};            // byte goes high
            end
            OP_LWD: begin
                regWrite = 1'b1;
                memRead = 1'b1;
                memToReg = 1'b1;
                aluSrcImm = 1'b1;
            end
            OP_SWD: begin
                memWrite = 1'b1;
                aluSrcImm = 1'b1;
                usesRt = 1'b1;                    // rt is the store data
            end
            OP_BNE: begin
                isBranch = 1'b1;
                usesRt = 1'b1;
            end
            OP_BEQ: begin
                isBranch = 1'b1;
                branchOnEq = 1'b1;
                usesRt = 1'b1;
            end
            OP_JMP: isJump = 1'b1;
            default: ;                            // unknown opcode acts as a nop
        endcase
    end

endmodule

//--- datapath/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit (
    input  cpuPkg::regAddrT idRs,
    input  cpuPkg::regAddrT idRt,
    input  logic            idUsesRt,
    input  cpuPkg::regAddrT exRs,
    input  cpuPkg::regAddrT exRt,
    input  logic            exMemRead,
    input  cpuPkg::regAddrT exWriteReg,
    input  cpuPkg::regAddrT memWriteReg,
    input  cpuPkg::regAddrT wbWriteReg,
    input  logic            exRegWrite,
    input  logic            memRegWrite,
    input  logic            wbRegWrite,
    output logic            stall,
    output cpuPkg::fwdSelE  fwdA,
    output cpuPkg::fwdSelE  fwdB
);
    import cpuPkg::*;

    // the younger producer wins
    function automatic fwdSelE pickSource(input regAddrT src);
        if (memRegWrite && memWriteReg == src) begin
            return FWD_FROMMEM;
        end
        if (wbRegWrite && wbWriteReg == src) begin
            return FWD_FROMWB;
        end
        return FWD_REGFILE;
    endfunction

    always_comb begin
        stall = exMemRead && exRegWrite
                && (exWriteReg == idRs || (idUsesRt && exWriteReg == idRt));
        fwdA = pickSource(exRs);
        fwdB = pickSource(exRt);
    end

endmodule

//--- datapath/datapath.sv
`timescale 1ns/100ps

module datapath (
    input  logic            clk,
    input  logic            rst,
    output logic            iRead,
    output cpuPkg::wordT    iAddr,
    input  cpuPkg::wordT    iData,
    output logic            dRead,
    output logic            dWrite,
    output cpuPkg::wordT    dAddr,
    output cpuPkg::wordT    dWData,
    input  cpuPkg::wordT    dRData,
    output cpuPkg::wordT    outputPort,
    output logic            wwdValid,
    output cpuPkg::wordT    numInst,
    output logic            isHalted,
    output cpuPkg::wordT    idInstr,
    input  logic            regWrite,
    input  logic            memRead,
    input  logic            memWrite,
    input  logic            memToReg,
    input  logic            aluSrcImm,
    input  cpuPkg::aluOpE   decAluOp,
    input  logic            isBranch,
    input  logic            branchOnEq,
    input  logic            isJump,
    input  logic            isWwd,
    input  logic            isHalt,
    input  logic            usesRt,
    input  cpuPkg::regAddrT writeReg,
    input  cpuPkg::wordT    imm,
    output cpuPkg::regAddrT rfReadA,
    output cpuPkg::regAddrT rfReadB,
    output cpuPkg::regAddrT rfWriteAddr,
    output cpuPkg::wordT    rfWriteData,
    output logic            rfWriteEn,
    input  cpuPkg::wordT    rfDataA,
    input  cpuPkg::wordT    rfDataB,
    output cpuPkg::wordT    aluA,
    output cpuPkg::wordT    aluB,
    output cpuPkg::aluOpE   aluOp,
    input  cpuPkg::wordT    aluResult,
    input  logic            aluZero,
    output cpuPkg::regAddrT idRs,
    output cpuPkg::regAddrT idRt,
    output logic            idUsesRt,
    output cpuPkg::regAddrT exRs,
    output cpuPkg::regAddrT exRt,
    output logic            exMemRead,
    output cpuPkg::regAddrT exWriteReg,
    output cpuPkg::regAddrT memWriteReg,
    output cpuPkg::regAddrT wbWriteReg,
    output logic            exRegWrite,
    output logic            memRegWrite,
    output logic            wbRegWrite,
    input  logic            stall,
    input  cpuPkg::fwdSelE  fwdA,
    input  cpuPkg::fwdSelE  fwdB
);
    import cpuPkg::*;

    wordT pc, pcPlus1;
    logic running;
    logic ifIdValid;
    wordT ifIdInstr, ifIdPcPlus1;
    logic idExValid;
    wordT idExPcPlus1, idExDataA, idExDataB, idExImm, idExJumpTarget;
    regAddrT idExRs, idExRt, idExWriteReg;
    logic idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg, idExAluSrcImm;
    logic idExBranch, idExBranchOnEq, idExJump, idExWwd, idExHalt;
    aluOpE idExAluOp;
    logic exMemValid;
    wordT exMemResult, exMemStoreData, exMemWwdData;
    regAddrT exMemWriteReg;
    logic exMemRegWrite, exMemMemRead, exMemMemWrite, exMemMemToReg, exMemWwd, exMemHalt;
    logic memWbValid, haltCounted;
    wordT memWbResult, memWbLoadData;
    regAddrT memWbWriteReg;
    logic memWbRegWrite, memWbMemToReg, memWbWwd, memWbHalt;
    wordT fwdDataA, fwdDataB, wbData, redirectTarget;
    logic redirect;

    function automatic wordT pickOperand(input fwdSelE sel, input wordT regValue);
        case (sel)
            FWD_FROMMEM: return exMemResult;
            FWD_FROMWB:  return wbData;
            default:     return regValue;
        endcase
    endfunction

    // IF and ID
    assign isHalted = memWbValid && memWbHalt;    // mem/wb freezes, so this holds
    assign iRead = running && !isHalted;
    assign iAddr = pc;
    assign pcPlus1 = pc + 1'b1;
    assign idInstr = ifIdInstr;
    assign rfReadA = ifIdInstr[11:10];
    assign rfReadB = ifIdInstr[9:8];
    assign idRs = ifIdInstr[11:10];
    assign idRt = ifIdInstr[9:8];
    assign idUsesRt = ifIdValid && usesRt;

    // hazard taps, qualified by the slot's valid bit
    assign exRs = idExRs;
    assign exRt = idExRt;
    assign exMemRead = idExValid && idExMemRead;
    assign exWriteReg = idExWriteReg;
    assign exRegWrite = idExValid && idExRegWrite;
    assign memWriteReg = exMemWriteReg;
    assign memRegWrite = exMemValid && exMemRegWrite;
    assign wbWriteReg = memWbWriteReg;
    assign wbRegWrite = memWbValid && memWbRegWrite;

    // EX
    always_comb begin
        fwdDataA = pickOperand(fwdA, idExDataA);
        fwdDataB = pickOperand(fwdB, idExDataB);
        redirect = idExValid && (idExJump || (idExBranch && aluZero == idExBranchOnEq));
        redirectTarget = idExJump ? idExJumpTarget : idExPcPlus1 + idExImm;
    end
    assign aluA = fwdDataA;
    assign aluB = idExAluSrcImm ? idExImm : fwdDataB;
    assign aluOp = idExAluOp;

    // MEM, held quiet once the halt is in WB
    assign dRead = exMemValid && exMemMemRead && !isHalted;
    assign dWrite = exMemValid && exMemMemWrite && !isHalted;
    assign dAddr = exMemResult;
    assign dWData = exMemStoreData;

    // WB
    assign wbData = memWbMemToReg ? memWbLoadData : memWbResult;
    assign rfWriteAddr = memWbWriteReg;
    assign rfWriteData = wbData;
    assign rfWriteEn = memWbValid && memWbRegWrite;
    assign wwdValid = memWbValid && memWbWwd;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            running <= 1'b0;
            ifIdValid <= 1'b0;
        end else if (!isHalted) begin
            running <= 1'b1;
            if (redirect) begin
                pc <= redirectTarget;
                ifIdValid <= 1'b0;                // flush the fetched slot
            end else if (!stall) begin
                if (iRead) begin
                    pc <= pcPlus1;
                end
                ifIdValid <= iRead;
                ifIdInstr <= iData;
                ifIdPcPlus1 <= pcPlus1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idExValid <= 1'b0;
        end else if (!isHalted) begin
            idExValid <= ifIdValid && !stall && !redirect;
            idExPcPlus1 <= ifIdPcPlus1;
            idExDataA <= rfDataA;
            idExDataB <= rfDataB;
            idExImm <= imm;
            idExJumpTarget <= {ifIdPcPlus1[15:12], ifIdInstr[11:0]};
            idExRs <= idRs;
            idExRt <= idRt;
            idExWriteReg <= writeReg;
            idExRegWrite <= regWrite;
            idExMemRead <= memRead;
            idExMemWrite <= memWrite;
            idExMemToReg <= memToReg;
            idExAluSrcImm <= aluSrcImm;
            idExAluOp <= decAluOp;
            idExBranch <= isBranch;
            idExBranchOnEq <= branchOnEq;
            idExJump <= isJump;
            idExWwd <= isWwd;
            idExHalt <= isHalt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exMemValid <= 1'b0;
        end else if (!isHalted) begin
            exMemValid <= idExValid;
            exMemResult <= aluResult;
            exMemStoreData <= fwdDataB;
            exMemWwdData <= fwdDataA;             // rs value for wwd
            exMemWriteReg <= idExWriteReg;
            exMemRegWrite <= idExRegWrite;
            exMemMemRead <= idExMemRead;
            exMemMemWrite <= idExMemWrite;
            exMemMemToReg <= idExMemToReg;
            exMemWwd <= idExWwd;
            exMemHalt <= idExHalt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            memWbValid <= 1'b0;
            haltCounted <= 1'b0;
            numInst <= '0;
            outputPort <= '0;
        end else begin
            if (memWbValid && !haltCounted) begin
                numInst <= numInst + 1'b1;        // hlt itself is counted once
            end
            if (isHalted) begin
                haltCounted <= 1'b1;
            end else begin
                memWbValid <= exMemValid;
                memWbResult <= exMemResult;
                memWbLoadData <= dRData;
                memWbWriteReg <= exMemWriteReg;
                memWbRegWrite <= exMemRegWrite;
                memWbMemToReg <= exMemMemToReg;
                memWbWwd <= exMemWwd;
                memWbHalt <= exMemHalt;
                if (exMemValid && exMemWwd) begin
                    outputPort <= exMemWwdData;   // valid while the wwd sits in WB
                end
            end
        end
    end

endmodule

//--- src/cpuTop.sv
`timescale 1ns/100ps

module cpuTop (
    input  logic         clk,
    input  logic         rst,
    output logic         iRead,
    output cpuPkg::wordT iAddr,
    input  cpuPkg::wordT iData,
    output logic         dRead,
    output logic         dWrite,
    output cpuPkg::wordT dAddr,
    output cpuPkg::wordT dWData,
    input  cpuPkg::wordT dRData,
    output cpuPkg::wordT outputPort,
    output logic         wwdValid,
    output cpuPkg::wordT numInst,
    output logic         isHalted
);
    import cpuPkg::*;

    wordT idInstr, imm;
    logic regWrite, memRead, memWrite, memToReg, aluSrcImm;
    logic isBranch, branchOnEq, isJump, isWwd, isHalt, usesRt;
    aluOpE decAluOp, aluOp;
    regAddrT writeReg;
    regAddrT rfReadA, rfReadB, rfWriteAddr;
    wordT rfWriteData, rfDataA, rfDataB;
    logic rfWriteEn;
    wordT aluA, aluB, aluResult;
    logic aluZero;
    regAddrT idRs, idRt, exRs, exRt, exWriteReg, memWriteReg, wbWriteReg;
    logic idUsesRt, exMemRead, exRegWrite, memRegWrite, wbRegWrite, stall;
    fwdSelE fwdA, fwdB;

    datapath dpInst (
        .clk, .rst, .iRead, .iAddr, .iData,
        .dRead, .dWrite, .dAddr, .dWData, .dRData,
        .outputPort, .wwdValid, .numInst, .isHalted, .idInstr,
        .regWrite, .memRead, .memWrite, .memToReg, .aluSrcImm, .decAluOp,
        .isBranch, .branchOnEq, .isJump, .isWwd, .isHalt, .usesRt, .writeReg, .imm,
        .rfReadA, .rfReadB, .rfWriteAddr, .rfWriteData, .rfWriteEn, .rfDataA, .rfDataB,
        .aluA, .aluB, .aluOp, .aluResult, .aluZero,
        .idRs, .idRt, .idUsesRt, .exRs, .exRt, .exMemRead,
        .exWriteReg, .memWriteReg, .wbWriteReg, .exRegWrite, .memRegWrite, .wbRegWrite,
        .stall, .fwdA, .fwdB
    );

    hazardUnit hazardInst (
        .idRs, .idRt, .idUsesRt, .exRs, .exRt, .exMemRead,
        .exWriteReg, .memWriteReg, .wbWriteReg, .exRegWrite, .memRegWrite, .wbRegWrite,
        .stall, .fwdA, .fwdB
    );

    controlUnit ctrlInst (
        .instr(idInstr), .regWrite, .memRead, .memWrite, .memToReg, .aluSrcImm,
        .aluOp(decAluOp), .isBranch, .branchOnEq, .isJump, .isWwd, .isHalt,
        .usesRt, .writeReg, .imm
    );

    regFile rfInst (
        .clk, .rst, .readA(rfReadA), .readB(rfReadB),
        .writeAddr(rfWriteAddr), .writeData(rfWriteData), .writeEn(rfWriteEn),
        .dataA(rfDataA), .dataB(rfDataB)
    );

    alu aluInst (
        .a(aluA), .b(aluB), .op(aluOp), .result(aluResult), .zero(aluZero)
    );

endmodule

//--- verification/cpuChecker.sv
`timescale 1ns/100ps

module cpuChecker #(
    parameter int MAX_WWD = 4
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         iRead,
    input  logic         wwdValid,
    input  cpuPkg::wordT outputPort,
    input  cpuPkg::wordT numInst,
    input  logic         isHalted,
    input  int           testIdx,
    input  cpuPkg::wordT expWwd [MAX_WWD],
    input  int           expWwdCount,
    input  cpuPkg::wordT expNumInst,
    input  logic         testEnd,
    input  logic         timedOut,
    output int           passCount,
    output int           failCount,
    output int           errorCount
);
    import cpuPkg::*;

    int wwdSeen = 0;
    int testErrors = 0;
    int passes = 0;
    int fails = 0;
    int errors = 0;
    logic haltSeen = 1'b0;
    logic released = 1'b0;

    assign passCount = passes;
    assign failCount = fails;
    assign errorCount = errors;

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            wwdSeen = 0;
            testErrors = 0;
            haltSeen = 1'b0;
            released = 1'b0;
        end else begin
            if (wwdValid) begin
                if (wwdSeen >= expWwdCount) begin
                    $display("test %0d: unexpected WWD output 0x%h after all expected values",
                             testIdx, outputPort);
                    testErrors++;
                end else if (outputPort !== expWwd[wwdSeen]) begin
                    $display("Mismatch outputPort: expected 0x%h, got 0x%h (test %0d, WWD %0d)",
                             expWwd[wwdSeen], outputPort, testIdx, wwdSeen);
                    testErrors++;
                end
                wwdSeen++;
            end
            if (isHalted && iRead) begin
                $display("test %0d: iRead still high while the processor is halted", testIdx);
                testErrors++;
            end
            if (released && !isHalted && !iRead) begin
                $display("test %0d: iRead low although the processor is running", testIdx);
                testErrors++;
            end
            released = 1'b1;                      // fetch starts one cycle after reset
            if (haltSeen && !isHalted) begin
                $display("test %0d: isHalted dropped although no reset was applied", testIdx);
                testErrors++;
            end
            haltSeen = isHalted;
            if (testEnd) begin
                if (timedOut) begin
                    $display("test %0d: processor did not halt before the timeout", testIdx);
                    testErrors++;
                end
                if (wwdSeen < expWwdCount) begin
                    $display("test %0d: only %0d of %0d WWD values appeared",
                             testIdx, wwdSeen, expWwdCount);
                    testErrors++;
                end
                if (numInst !== expNumInst) begin
                    $display("Mismatch numInst: expected 0x%h, got 0x%h (test %0d)",
                             expNumInst, numInst, testIdx);
                    testErrors++;
                end
                if (testErrors == 0) begin
                    passes++;
                    $display("test %0d passed, %0d WWD values, numInst %0d",
                             testIdx, wwdSeen, numInst);
                end else begin
                    fails++;
                    $display("test %0d failed with %0d errors", testIdx, testErrors);
                end
                errors += testErrors;
            end
        end
    end

endmodule

//--- verification/tbCpu.sv
`timescale 1ns/100ps

module tbCpu;
    import cpuPkg::*;

    localparam int NUM_TESTS = 6;
    localparam int MAX_PROG = 16;
    localparam int MAX_WWD = 4;
    localparam int MEM_WORDS = 256;
    localparam int TIMEOUT_CYCLES = 100;

    // isa field values
    localparam int BNE_OPC = 0;
    localparam int BEQ_OPC = 1;
    localparam int ADI_OPC = 4;
    localparam int LHI_OPC = 6;
    localparam int LWD_OPC = 7;
    localparam int SWD_OPC = 8;
    localparam int ADD_FN = 0;
    localparam int SUB_FN = 1;
    localparam int AND_FN = 2;
    localparam int ORR_FN = 3;
    localparam int WWD_FN = 28;
    localparam int HLT_FN = 29;

    logic clk;
    logic rst;
    logic iRead;
    wordT iAddr;
    wordT iData;
    logic dRead;
    logic dWrite;
    wordT dAddr;
    wordT dWData;
    wordT dRData;
    wordT outputPort;
    logic wwdValid;
    wordT numInst;
    logic isHalted;

    wordT imem [MEM_WORDS];
    wordT dmem [MEM_WORDS];
    wordT presetData [MEM_WORDS];
    int seed;

    wordT progTable [NUM_TESTS][MAX_PROG];
    int progLen [NUM_TESTS];
    wordT wwdTable [NUM_TESTS][MAX_WWD];
    int wwdCount [NUM_TESTS];
    int numInstTable [NUM_TESTS];
    int timeoutTable [NUM_TESTS];

    int testIdx;
    wordT curWwd [MAX_WWD];
    int curWwdCount;
    wordT curNumInst;
    logic testEnd;
    logic timedOut;
    int passCount;
    int failCount;
    int errorCount;

    cpuTop dut_i (
        .clk, .rst, .iRead, .iAddr, .iData, .dRead, .dWrite, .dAddr, .dWData, .dRData,
        .outputPort, .wwdValid, .numInst, .isHalted
    );

    cpuChecker #(.MAX_WWD(MAX_WWD)) checkInst (
        .clk, .rst, .iRead, .wwdValid, .outputPort, .numInst, .isHalted, .testIdx,
        .expWwd(curWwd), .expWwdCount(curWwdCount), .expNumInst(curNumInst),
        .testEnd, .timedOut, .passCount, .failCount, .errorCount
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // both memories answer in the same cycle
    assign iData = imem[iAddr[7:0]];
    assign dRData = dRead ? dmem[dAddr[7:0]] : '0;   // data only while strobed

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                dmem[i] <= presetData[i];         // fresh contents for every test
            end
        end else if (dWrite) begin
            dmem[dAddr[7:0]] <= dWData;
        end
    end

    function automatic wordT encR(input int func, input int rd, input int rs, input int rt);
        return {4'hF, 2'(rs), 2'(rt), 2'(rd), 6'(func)};
    endfunction

    function automatic wordT encI(input int op, input int rs, input int rt, input int imm);
        return {4'(op), 2'(rs), 2'(rt), 8'(imm)};
    endfunction

    function automatic wordT encJmp(input int target);
        return {4'd9, 12'(target)};
    endfunction

    function automatic wordT signExt8(input logic [7:0] v);
        return {{8{v[7]}}, v};
    endfunction

    task automatic addWord(input int t, input wordT w);
        progTable[t][progLen[t]] = w;
        progLen[t]++;
    endtask

    task automatic addWwd(input int t, input wordT v);
        wwdTable[t][wwdCount[t]] = v;
        wwdCount[t]++;
    endtask

    // skipped or frozen instructions never retire
    task automatic setRetired(input int t, input int notRetired);
        numInstTable[t] = progLen[t] - notRetired;
        timeoutTable[t] = TIMEOUT_CYCLES;
    endtask

    task automatic buildTable();
        wordT sum;
        wordT diff;
        wordT both;
        wordT stored;
        for (int t = 0; t < NUM_TESTS; t++) begin
            progLen[t] = 0;
            wwdCount[t] = 0;
            for (int i = 0; i < MAX_PROG; i++) begin
                progTable[t][i] = '0;             // decodes as a never-taken bne
            end
        end
        // dependent alu chain with every operand forwarded
        addWord(0, encI(ADI_OPC, 0, 1, 12));
        addWord(0, encI(ADI_OPC, 0, 2, 10));
        addWord(0, encR(ADD_FN, 3, 1, 2));
        addWord(0, encR(SUB_FN, 1, 3, 2));
        addWord(0, encR(AND_FN, 2, 3, 1));
        addWord(0, encR(ORR_FN, 0, 2, 3));
        addWord(0, encR(WWD_FN, 0, 3, 0));
        addWord(0, encR(WWD_FN, 0, 1, 0));
        addWord(0, encR(WWD_FN, 0, 2, 0));
        addWord(0, encR(WWD_FN, 0, 0, 0));
        addWord(0, encR(HLT_FN, 0, 0, 0));
        sum = 16'd12 + 16'd10;
        diff = sum - 16'd10;
        both = sum & diff;
        addWwd(0, sum);
        addWwd(0, diff);
        addWwd(0, both);
        addWwd(0, both | sum);
        setRetired(0, 0);
        // immediates
        addWord(1, encI(ADI_OPC, 0, 1, -3));
        addWord(1, encI(LHI_OPC, 0, 2, 'hA5));
        addWord(1, encI(ADI_OPC, 2, 3, -1));
        addWord(1, encR(WWD_FN, 0, 1, 0));
        addWord(1, encR(WWD_FN, 0, 2, 0));
        addWord(1, encR(WWD_FN, 0, 3, 0));
        addWord(1, encR(HLT_FN, 0, 0, 0));
        addWwd(1, signExt8(8'hFD));
        addWwd(1, {8'hA5, 8'h00});
        addWwd(1, {8'hA5, 8'h00} + signExt8(8'hFF));
        setRetired(1, 0);
        // store and load back before two load-use pairs
        addWord(2, encI(ADI_OPC, 0, 1, 'h40));
        addWord(2, encI(LHI_OPC, 0, 2, 'h12));
        addWord(2, encI(ADI_OPC, 2, 2, 'h34));
        addWord(2, encI(SWD_OPC, 1, 2, 2));
        addWord(2, encI(LWD_OPC, 1, 3, 2));
        addWord(2, encR(WWD_FN, 0, 3, 0));
        addWord(2, encI(LWD_OPC, 1, 0, 5));
        addWord(2, encR(ADD_FN, 3, 0, 2));
        addWord(2, encR(WWD_FN, 0, 3, 0));
        addWord(2, encR(HLT_FN, 0, 0, 0));
        stored = {8'h12, 8'h00} + 16'h0034;
        addWwd(2, stored);
        addWwd(2, presetData[8'h40 + 5] + stored);
        setRetired(2, 0);
        // taken branches go to pc + 1 + imm
        addWord(3, encI(ADI_OPC, 0, 1, 7));
        addWord(3, encI(ADI_OPC, 0, 2, 7));
        addWord(3, encI(ADI_OPC, 0, 3, 9));
        addWord(3, encI(BEQ_OPC, 1, 2, 2));   // taken to 6
        addWord(3, encR(WWD_FN, 0, 3, 0));
        addWord(3, encR(WWD_FN, 0, 3, 0));
        addWord(3, encI(BNE_OPC, 1, 2, 2));   // falls through
        addWord(3, encR(WWD_FN, 0, 1, 0));
        addWord(3, encI(BEQ_OPC, 1, 3, 1));   // falls through
        addWord(3, encR(WWD_FN, 0, 3, 0));
        addWord(3, encI(BNE_OPC, 1, 3, 2));   // taken to 13
        addWord(3, encR(WWD_FN, 0, 1, 0));
        addWord(3, encR(WWD_FN, 0, 2, 0));
        addWord(3, encR(ADD_FN, 0, 1, 3));
        addWord(3, encR(WWD_FN, 0, 0, 0));
        addWord(3, encR(HLT_FN, 0, 0, 0));
        addWwd(3, 16'd7);
        addWwd(3, 16'd9);
        addWwd(3, 16'd7 + 16'd9);
        setRetired(3, 4);
        // jumps
        addWord(4, encI(ADI_OPC, 0, 1, 'h11));
        addWord(4, encJmp(4));
        addWord(4, encR(WWD_FN, 0, 1, 0));
        addWord(4, encI(ADI_OPC, 1, 1, 1));
        addWord(4, encR(WWD_FN, 0, 1, 0));
        addWord(4, encJmp(8));
        addWord(4, encR(HLT_FN, 0, 0, 0));
        addWord(4, encR(WWD_FN, 0, 1, 0));
        addWord(4, encI(ADI_OPC, 1, 1, 2));
        addWord(4, encR(WWD_FN, 0, 1, 0));
        addWord(4, encR(HLT_FN, 0, 0, 0));
        addWwd(4, 16'h0011);
        addWwd(4, 16'h0013);
        setRetired(4, 4);
        // everything behind hlt stays frozen
        addWord(5, encI(ADI_OPC, 0, 2, 'h2B));
        addWord(5, encR(WWD_FN, 0, 2, 0));
        addWord(5, encR(HLT_FN, 0, 0, 0));
        addWord(5, encR(WWD_FN, 0, 2, 0));
        addWord(5, encR(WWD_FN, 0, 2, 0));
        addWord(5, encI(ADI_OPC, 2, 2, 1));
        addWord(5, encR(WWD_FN, 0, 2, 0));
        addWwd(5, 16'h002B);
        setRetired(5, 4);
    endtask

    task automatic loadRow(input int t);
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            if (i < MAX_PROG) begin
                imem[i] = progTable[t][i];
            end
        end
        for (int i = 0; i < MAX_WWD; i++) begin
            curWwd[i] = wwdTable[t][i];
        end
        curWwdCount = wwdCount[t];
        curNumInst = 16'(numInstTable[t]);
        testIdx = t;
    endtask

    task automatic runTest(input int t);
        int cycles;
        logic halted;
        @(posedge clk);
        rst <= 1'b1;
        loadRow(t);
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        while (!isHalted && cycles < timeoutTable[t]) begin
            @(negedge clk);
            cycles++;
        end
        halted = isHalted;
        repeat (10) @(negedge clk);               // room for a stray wwd pulse
        @(posedge clk);
        timedOut <= !halted;
        testEnd <= 1'b1;
        @(posedge clk);
        testEnd <= 1'b0;
        timedOut <= 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        testEnd = 1'b0;
        timedOut = 1'b0;
        testIdx = 0;
        curWwdCount = 0;
        curNumInst = '0;
        seed = 50;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            presetData[i] = 16'($random(seed));
        end
        for (int i = 0; i < MAX_WWD; i++) begin
            curWwd[i] = '0;
        end
        buildTable();
        for (int t = 0; t < NUM_TESTS; t++) begin
            runTest(t);
        end
        @(negedge clk);
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 NUM_TESTS, passCount, failCount, errorCount);
        if (passCount == NUM_TESTS && failCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- verilog.f
common/cpuPkg.sv
src/regFile.sv
src/alu.sv
src/controlUnit.sv
datapath/hazardUnit.sv
datapath/datapath.sv
src/cpuTop.sv
verification/cpuChecker.sv
verification/tbCpu.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tbCpu -f verilog.f --Mdir obj_dir -o simCpu
	./obj_dir/simCpu | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
